// ==== design/ethSwitchPkg.sv ====
// Sizes, info word layout and word types shared by the switch core
// Import where the port count, queue depths or word types are needed
`default_nettype none

package ethSwitchPkg;

    // ----------------------------------------
    // Sizes and host timing
    // ----------------------------------------
    localparam int numPorts    = 2;    // Single-bit curPort relies on two ports
    localparam int dataDepth   = 64;   // Words per data queue
    localparam int infoDepth   = 4;    // Frames per info queue
    localparam int recvSpacing = 4;    // Cycles between recvReady pulses
    localparam int sendSpacing = 3;    // Cycles between sendReady pulses

    typedef logic [15:0] dataWord;             // One frame word, two bytes
    typedef logic [numPorts-1:0] portMask;     // One bit per port

    // Info word, one per frame, in both the receive and send directions
    typedef struct packed {
        logic        flush;        // Bit 31, frame to be discarded
        logic [6:0]  rsvdHi;
        logic [7:0]  firstByte;    // Bits 23:16
        logic [3:0]  rsvdLo;
        logic [11:0] byteCount;    // Bits 11:0
    } infoWord;

endpackage

`default_nettype wire

// ==== design/queueIf.sv ====
// Write and read sides of one synchronous FIFO
// payload selects the entry type, data words or info words
`timescale 1ns/1ns
`default_nettype none

interface queueIf #(
    parameter type payload = ethSwitchPkg::dataWord
) ();
    logic   wrEn;     // Write strobe, ignored while full
    payload din;
    logic   full;
    logic   rdEn;     // Pops the head entry
    payload dout;     // Head entry, valid while not empty
    logic   empty;

    modport writer (
        output wrEn, din,
        input  full
    );

    modport fifo (
        input  wrEn, din, rdEn,
        output full, dout, empty
    );

    modport reader (
        output rdEn,
        input  dout, empty
    );

endinterface

`default_nettype wire

// ==== design/syncFifo.sv ====
// Synchronous FIFO with a first-word-through head, one clock domain
// Holds either receive/send data words or info words
`timescale 1ns/1ns
`default_nettype none

module syncFifo #(
    parameter type payload = logic [15:0],
    parameter int  depth   = 4
) (
    input  wire clk,
    input  wire arstN,
    queueIf.fifo q
);

    payload mem [depth];
    logic [$clog2(depth)-1:0]   wrPtr;
    logic [$clog2(depth)-1:0]   rdPtr;
    logic [$clog2(depth+1)-1:0] count;    // Entries held
    logic wrDo;
    logic rdDo;

    assign wrDo    = q.wrEn && !q.full;
    assign rdDo    = q.rdEn && !q.empty;
    assign q.full  = int'(count) == depth;
    assign q.empty = count == '0;
    assign q.dout  = mem[rdPtr];          // Head shows as soon as count rises

    always_ff @(posedge clk) begin
        if (wrDo) mem[wrPtr] <= q.din;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrDo)
                wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;   // Wrap
            if (rdDo)
                rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
            case ({wrDo, rdDo})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

    // ----------------------------------------
    // Queue protocol, owed by the producer and consumer modules
    // ----------------------------------------
    writeWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        q.wrEn |-> !q.full);

    readWhenEmpty: assert property (@(posedge clk) disable iff (!arstN)
        q.rdEn |-> !q.empty);

endmodule

`default_nettype wire

// ==== design/rxFrameWriter.sv ====
// Per-port producer; stores each received word in the data queue
// and closes the frame with one info entry a cycle after the last word
`timescale 1ns/1ns
`default_nettype none

module rxFrameWriter (
    input  wire                  clk,
    input  wire                  arstN,
    input  logic                 rxValid,    // Word strobe from the port
    input  ethSwitchPkg::dataWord rxWord,
    input  logic                 rxLast,     // Marks the final word of a frame
    input  logic                 rxBad,      // Port flagged the frame, qualified by rxLast
    queueIf.writer               dataQ,
    queueIf.writer               infoQ
);
    import ethSwitchPkg::*;

    logic [10:0] wordCnt;      // Words seen so far in this frame
    logic        flushAcc;     // Some word met a full data queue
    logic        infoPend;     // Info entry due this cycle
    logic [7:0]  firstByteQ;
    infoWord     infoReg;

    // Data words go straight in, dropped if the queue is full
    assign dataQ.wrEn = rxValid && !dataQ.full;
    assign dataQ.din  = rxWord;

    // Frame lost completely when the info queue has no room
    assign infoQ.wrEn = infoPend && !infoQ.full;
    assign infoQ.din  = infoReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wordCnt  <= '0;
            flushAcc <= 1'b0;
            infoPend <= 1'b0;
        end else begin
            infoPend <= 1'b0;
            if (rxValid) begin
                if (rxLast) begin
                    wordCnt  <= '0;          // Next word starts a new frame
                    flushAcc <= 1'b0;
                    infoPend <= 1'b1;
                end else begin
                    wordCnt  <= wordCnt + 11'd1;
                    flushAcc <= flushAcc | dataQ.full;
                end
            end
        end
    end

    // Frame summary, built on the last word
    always_ff @(posedge clk) begin
        if (rxValid && wordCnt == '0)
            firstByteQ <= rxWord[15:8];     // Upper byte of word 0
        if (rxValid && rxLast)
            infoReg <= '{
                flush:     flushAcc | dataQ.full | rxBad,
                firstByte: (wordCnt == '0) ? rxWord[15:8] : firstByteQ,
                byteCount: {wordCnt + 11'd1, 1'b0},   // Two bytes per word
                default:   '0
            };
    end

endmodule

`default_nettype wire

// ==== design/ethSwitchRt.sv ====
// Port arbiter and host-side FSM of the switch core
// Hands receive frames to the host word by word and queues host words for send
`timescale 1ns/1ns
`default_nettype none

module ethSwitchRt (
    input  wire                   clk,
    input  wire                   arstN,
    input  ethSwitchPkg::portMask initOk,            // Port ready for traffic
    input  ethSwitchPkg::portMask clearErrors,
    input  logic                  sendReq,           // Host wants to forward a frame
    input  logic                  responseRequired,
    input  logic                  recvBusy,
    input  logic                  sendBusy,
    input  logic [11:0]           responseByteCount,
    input  ethSwitchPkg::dataWord sendWord,
    output logic                  recvRequest,
    output logic                  recvReady,
    output logic                  sendRequest,
    output logic                  sendReady,
    output logic                  isForward,
    output logic                  curPort,
    output ethSwitchPkg::dataWord recvWord,
    output logic [15:0]           timeReceive,
    output ethSwitchPkg::portMask recvFifoError,     // Word 0 disagrees with firstByte
    output ethSwitchPkg::portMask sendOverflow,      // Send data queue ran full
    queueIf.reader                rxDataQ [ethSwitchPkg::numPorts],
    queueIf.reader                rxInfoQ [ethSwitchPkg::numPorts],
    queueIf.writer                txDataQ [ethSwitchPkg::numPorts],
    queueIf.writer                txInfoQ [ethSwitchPkg::numPorts]
);
    import ethSwitchPkg::*;

    typedef enum logic [2:0] {stIdle, stRecvWait, stRecv, stSendWait, stSend} fsmState;

    fsmState state;
    dataWord rxDataDout [numPorts];
    infoWord rxInfoDout [numPorts];
    portMask rxDataEmpty, rxInfoEmpty, txDataFull, txInfoFull;
    portMask txWrEn, txInfoWrEn;     // Registered strobes, one port at a time
    dataWord txDin;
    infoWord txInfoDin;
    infoWord curInfo;

    logic [recvSpacing-1:0] recvRing;    // Ready, valid, transition, wait
    logic [sendSpacing-1:0] sendCtrl;    // Ready, valid, idle slot
    logic [10:0] rxWords;                // Words in the current frame
    logic [10:0] recvCnt;                // Words handed over so far
    logic [15:0] timeNow;                // Runs from the start of a receive
    logic [7:0]  firstByteExp;
    logic [7:0]  sendFirstByte;
    logic pktValid, sendFlush, sendFirst;
    logic fwdStart, rxStart, lastWord, infoPop, dataPop;

    // ----------------------------------------
    // Queue hookup per port
    // ----------------------------------------
    for (genvar p = 0; p < numPorts; p++) begin : genPort
        assign rxDataDout[p]    = rxDataQ[p].dout;
        assign rxDataEmpty[p]   = rxDataQ[p].empty;
        assign rxInfoDout[p]    = rxInfoQ[p].dout;
        assign rxInfoEmpty[p]   = rxInfoQ[p].empty;
        assign rxDataQ[p].rdEn  = dataPop && curPort == 1'(p);
        assign rxInfoQ[p].rdEn  = infoPop && curPort == 1'(p);
        assign txDataFull[p]    = txDataQ[p].full;
        assign txInfoFull[p]    = txInfoQ[p].full;
        assign txDataQ[p].wrEn  = txWrEn[p];
        assign txDataQ[p].din   = txDin;            // Shared, only curPort writes
        assign txInfoQ[p].wrEn  = txInfoWrEn[p];
        assign txInfoQ[p].din   = txInfoDin;
    end

    assign curInfo   = rxInfoDout[curPort];
    assign recvReady = recvRing[0];
    assign sendReady = sendCtrl[0];
    assign fwdStart  = initOk[curPort] && sendReq && !txDataFull[curPort];   // Wins over receive
    assign rxStart   = initOk[curPort] && !fwdStart && !rxInfoEmpty[curPort];
    assign lastWord  = 12'(recvCnt) + 12'd1 >= 12'(rxWords);
    assign infoPop   = state == stIdle && rxStart;
    // Word 0 leaves with the info entry, the rest after each valid phase
    assign dataPop   = (infoPop || (state == stRecv && recvRing[1] && !lastWord))
                       && !rxDataEmpty[curPort];

    always_ff @(posedge clk) begin
        if (dataPop) recvWord <= rxDataDout[curPort];   // Held until the next ready pulse
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state         <= stIdle;
            curPort       <= 1'b0;
            recvRequest   <= 1'b0;
            sendRequest   <= 1'b0;
            isForward     <= 1'b0;
            recvRing      <= '0;
            sendCtrl      <= {1'b1, {(sendSpacing-1){1'b0}}};
            recvFifoError <= '0;
            sendOverflow  <= '0;
            txWrEn        <= '0;
            txInfoWrEn    <= '0;
            timeNow       <= '0;
            recvCnt       <= '0;
            rxWords       <= '0;
            pktValid      <= 1'b0;
            sendFlush     <= 1'b0;
            sendFirst     <= 1'b1;
            firstByteExp  <= '0;
            sendFirstByte <= '0;
            timeReceive   <= '0;
            txDin         <= '0;
            txInfoDin     <= '0;
        end else begin
            recvFifoError <= recvFifoError & ~clearErrors;
            sendOverflow  <= sendOverflow & ~clearErrors;
            unique case (state)
                stIdle: begin
                    timeNow    <= '0;
                    recvCnt    <= '0;
                    isForward  <= 1'b0;
                    txInfoWrEn <= '0;
                    sendFirst  <= 1'b1;
                    if (fwdStart) begin
                        isForward   <= 1'b1;          // Host-originated frame
                        sendRequest <= 1'b1;
                        state       <= stSendWait;
                    end else if (rxStart) begin
                        rxWords      <= curInfo.byteCount[11:1];
                        firstByteExp <= curInfo.firstByte;
                        pktValid     <= !curInfo.flush;
                        recvRequest  <= !curInfo.flush;    // Flushed frames skip the host
                        recvRing     <= '0;
                        state        <= curInfo.flush ? stRecv : stRecvWait;
                    end else if (initOk[~curPort] && !rxInfoEmpty[~curPort]) begin
                        curPort <= ~curPort;          // Only when this port is quiet
                    end
                end
                stRecvWait: begin
                    timeNow <= timeNow + 16'd1;
                    if (recvBusy) begin
                        recvRequest <= 1'b0;
                        recvRing    <= recvSpacing'(1);    // First ready pulse
                        state       <= stRecv;
                    end
                end
                stRecv: begin
                    timeNow <= timeNow + 16'd1;
                    // Host gone means valid and transition every cycle, so words drain
                    recvRing[0] <= recvBusy & recvRing[3];
                    recvRing[1] <= ~recvBusy | recvRing[0];
                    recvRing[2] <= ~recvBusy | recvRing[1];
                    recvRing[3] <= recvRing[2];
                    if (recvRing[1] && recvCnt == '0 && pktValid)
                        recvFifoError[curPort] <= recvWord[15:8] != firstByteExp;
                    if (recvRing[2]) begin
                        if (lastWord) begin
                            sendRequest <= pktValid & responseRequired;
                            timeReceive <= timeNow;
                            state <= (pktValid & responseRequired) ? stSendWait : stIdle;
                        end else begin
                            recvCnt <= recvCnt + 11'd1;
                        end
                    end
                end
                stSendWait: begin
                    timeNow <= timeNow + 16'd1;
                    if (sendBusy) begin
                        sendRequest <= 1'b0;
                        sendFlush   <= 1'b0;
                        sendCtrl    <= sendSpacing'(1);
                        state       <= stSend;
                    end
                end
                stSend: begin
                    timeNow <= timeNow + 16'd1;
                    txWrEn  <= '0;
                    if (sendBusy) begin
                        sendCtrl <= {sendCtrl[sendSpacing-2:0], sendCtrl[sendSpacing-1]};
                        if (sendCtrl[1]) begin                // Host word settled
                            txDin <= {sendWord[7:0], sendWord[15:8]};   // Byte swap
                            txWrEn[curPort] <= !(txDataFull[curPort] || sendFlush);
                            if (txDataFull[curPort]) begin
                                sendFlush             <= 1'b1;   // Rest of the send is dropped
                                sendOverflow[curPort] <= 1'b1;
                            end
                            if (sendFirst) begin
                                sendFirstByte <= sendWord[7:0];
                                sendFirst     <= 1'b0;
                            end
                        end
                    end else begin
                        // Host done, close the frame with its info word
                        sendCtrl  <= {1'b1, {(sendSpacing-1){1'b0}}};
                        txInfoDin <= '{
                            flush:     sendFlush,
                            firstByte: sendFirstByte,
                            byteCount: responseByteCount,
                            default:   '0
                        };
                        txInfoWrEn[curPort] <= !txInfoFull[curPort];
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // A port change mid-frame would mix queues of two ports
    portOnlyInIdle: assert property (@(posedge clk) disable iff (!arstN)
        $changed(curPort) |-> $past(state) == stIdle);

endmodule

`default_nettype wire

// ==== design/ethSwitchTop.sv ====
// Switch core top level; two port writers, eight FIFOs and the switch
// Port side and host side come out as plain ports
`timescale 1ns/1ns
`default_nettype none

module ethSwitchTop (
    input  wire                                                   clk,
    input  wire                                                   arstN,
    // Port receivers
    input  ethSwitchPkg::portMask                                 rxValid,
    input  ethSwitchPkg::dataWord [ethSwitchPkg::numPorts-1:0]    rxWord,
    input  ethSwitchPkg::portMask                                 rxLast,
    input  ethSwitchPkg::portMask                                 rxBad,
    // Port transmit queues, read side
    input  ethSwitchPkg::portMask                                 txRdEn,
    output ethSwitchPkg::dataWord [ethSwitchPkg::numPorts-1:0]    txWord,
    output ethSwitchPkg::portMask                                 txEmpty,
    input  ethSwitchPkg::portMask                                 txInfoRdEn,
    output ethSwitchPkg::infoWord [ethSwitchPkg::numPorts-1:0]    txInfo,
    output ethSwitchPkg::portMask                                 txInfoEmpty,
    // Host side
    input  ethSwitchPkg::portMask                                 initOk,
    input  ethSwitchPkg::portMask                                 clearErrors,
    input  logic                                                  sendReq,
    input  logic                                                  responseRequired,
    input  logic                                                  recvBusy,
    input  logic                                                  sendBusy,
    input  logic [11:0]                                           responseByteCount,
    input  ethSwitchPkg::dataWord                                 sendWord,
    output logic                                                  recvRequest,
    output logic                                                  recvReady,
    output logic                                                  sendRequest,
    output logic                                                  sendReady,
    output logic                                                  isForward,
    output logic                                                  curPort,
    output ethSwitchPkg::dataWord                                 recvWord,
    output logic [15:0]                                           timeReceive,
    output ethSwitchPkg::portMask                                 recvFifoError,
    output ethSwitchPkg::portMask                                 sendOverflow
);
    import ethSwitchPkg::*;

    queueIf #(.payload(dataWord)) rxDataQ [numPorts] ();
    queueIf #(.payload(infoWord)) rxInfoQ [numPorts] ();
    queueIf #(.payload(dataWord)) txDataQ [numPorts] ();
    queueIf #(.payload(infoWord)) txInfoQ [numPorts] ();

    // ----------------------------------------
    // Per-port writer and queues
    // ----------------------------------------
    for (genvar p = 0; p < numPorts; p++) begin : genPort
        rxFrameWriter writer (
            .clk, .arstN,
            .rxValid(rxValid[p]), .rxWord(rxWord[p]),
            .rxLast(rxLast[p]), .rxBad(rxBad[p]),
            .dataQ(rxDataQ[p]), .infoQ(rxInfoQ[p])
        );

        syncFifo #(.payload(dataWord), .depth(dataDepth)) rxDataFifo (.clk, .arstN, .q(rxDataQ[p]));
        syncFifo #(.payload(infoWord), .depth(infoDepth)) rxInfoFifo (.clk, .arstN, .q(rxInfoQ[p]));
        syncFifo #(.payload(dataWord), .depth(dataDepth)) txDataFifo (.clk, .arstN, .q(txDataQ[p]));
        syncFifo #(.payload(infoWord), .depth(infoDepth)) txInfoFifo (.clk, .arstN, .q(txInfoQ[p]));

        // Transmit side is drained outside the core
        assign txDataQ[p].rdEn = txRdEn[p];
        assign txWord[p]       = txDataQ[p].dout;
        assign txEmpty[p]      = txDataQ[p].empty;
        assign txInfoQ[p].rdEn = txInfoRdEn[p];
        assign txInfo[p]       = txInfoQ[p].dout;
        assign txInfoEmpty[p]  = txInfoQ[p].empty;
    end

    ethSwitchRt switchRt (
        .clk, .arstN,
        .initOk, .clearErrors, .sendReq, .responseRequired,
        .recvBusy, .sendBusy, .responseByteCount, .sendWord,
        .recvRequest, .recvReady, .sendRequest, .sendReady,
        .isForward, .curPort, .recvWord, .timeReceive,
        .recvFifoError, .sendOverflow,
        .rxDataQ, .rxInfoQ, .txDataQ, .txInfoQ
    );

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
// Testbench clock and active-low reset source
// Reset is released on a falling edge after resetCycles rising edges
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int period      = 10,    // ns
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;                          // Held from time zero
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;                          // Away from the active edge
    end

endmodule

`default_nettype wire

// ==== sim/ethSwitchTb.sv ====
// Directed tests for the switch core; the testbench plays both port receivers and the host
// Inputs change on the falling edge, outputs are sampled there too
`timescale 1ns/1ns
`default_nettype none

module ethSwitchTb;
    import ethSwitchPkg::*;

    localparam int waitLimit = 400;      // Cycles allowed for any single wait

    logic clk;
    logic arstN;
    portMask rxValid, rxLast, rxBad, txRdEn, txEmpty, txInfoRdEn, txInfoEmpty;
    portMask initOk, clearErrors, recvFifoError, sendOverflow;
    dataWord [numPorts-1:0] rxWord;
    dataWord [numPorts-1:0] txWord;
    infoWord [numPorts-1:0] txInfo;
    logic sendReq, responseRequired, recvBusy, sendBusy;
    logic recvRequest, recvReady, sendRequest, sendReady, isForward, curPort;
    logic [11:0] responseByteCount;
    logic [15:0] timeReceive;
    dataWord sendWord, recvWord;

    dataWord frame[$];      // Words of the last frame put on a port
    dataWord sentQ[$];      // Words the host gave during the last send

    clockGen #(.period(10), .resetCycles(5)) clkGen (.clk, .arstN);

    ethSwitchTop uut (.*);

    // ----------------------------------------
    // Failure reporting and compares
    // ----------------------------------------
    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input dataWord got, input dataWord exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            failRun("word compare failed");
        end
    endtask

    task automatic checkInfo(input string name, input infoWord got, input infoWord exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            failRun("info word compare failed");
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            failRun("flag compare failed");
        end
    endtask

    // One falling edge of a bounded wait
    task automatic stepOrTimeout(input string what, inout int guard);
        @(negedge clk);
        guard++;
        if (guard > waitLimit)
            failRun({"timeout while waiting for ", what});
    endtask

    // ----------------------------------------
    // Port and host side drivers
    // ----------------------------------------
    task automatic sendFrame(input logic port, input int len, input logic bad);
        frame.delete();
        for (int i = 0; i < len; i++)
            frame.push_back(dataWord'($urandom()));
        for (int i = 0; i < len; i++) begin
            rxValid[port] = 1'b1;
            rxWord[port]  = frame[i];
            rxLast[port]  = (i == len - 1);
            rxBad[port]   = bad && (i == len - 1);   // Port verdict rides on the last word
            @(negedge clk);
        end
        rxValid[port] = 1'b0;
        rxLast[port]  = 1'b0;
        rxBad[port]   = 1'b0;
    endtask

    // Host accepts one frame and expects the words of frame in order
    task automatic receiveFrame(input logic port);
        int guard;
        int elapsed;                     // Cycles since recvRequest was seen
        guard = 0;
        while (!recvRequest)
            stepOrTimeout("recvRequest", guard);
        checkFlag("curPort", curPort, port);
        recvBusy = 1'b1;
        elapsed  = 0;
        for (int k = 0; k < frame.size(); k++) begin
            guard = 0;
            do begin
                stepOrTimeout("recvReady", guard);
                elapsed++;
            end while (!recvReady);
            checkWord("recvWord", recvWord, frame[k]);
        end
        recvBusy = 1'b0;                 // Host done after the last word
        checkFlag("recvFifoError", recvFifoError[port], 1'b0);
        repeat (2 * recvSpacing) begin
            @(negedge clk);
            if (recvReady)
                failRun("recvReady pulsed after the last word of the frame");
        end
        // Receive time runs from the request cycle to the closing cycle after the last pulse
        checkWord("timeReceive", timeReceive, 16'(elapsed + 1));
    endtask

    // Answers sendReady pulses with random words, caller already saw sendRequest
    task automatic respondSend(input int count);
        int guard;
        dataWord w;
        sendBusy = 1'b1;
        sentQ.delete();
        for (int i = 0; i < count; i++) begin
            guard = 0;
            do
                stepOrTimeout("sendReady", guard);
            while (!sendReady);
            w = dataWord'($urandom());
            sendWord = w;                // Sampled one cycle after the pulse
            sentQ.push_back(w);
        end
        @(negedge clk);
        @(negedge clk);                  // Let the last word be taken
        sendBusy = 1'b0;
    endtask

    task automatic drainTx(input int count);
        int guard;
        dataWord exp;
        for (int i = 0; i < count; i++) begin
            guard = 0;
            while (txEmpty[0])
                stepOrTimeout("txWord", guard);
            exp = {sentQ[i][7:0], sentQ[i][15:8]};     // Bytes swapped on the way out
            checkWord("txWord[0]", txWord[0], exp);
            txRdEn[0] = 1'b1;
            @(negedge clk);
            txRdEn[0] = 1'b0;
        end
    endtask

    task automatic readTxInfo(input logic flush, input logic [7:0] first,
                              input logic [11:0] bytes);
        int guard;
        infoWord exp;
        guard = 0;
        while (txInfoEmpty[0])
            stepOrTimeout("txInfo", guard);
        exp        = '0;
        exp[11:0]  = bytes;
        exp[23:16] = first;
        exp[31]    = flush;
        checkInfo("txInfo[0]", txInfo[0], exp);
        txInfoRdEn[0] = 1'b1;
        @(negedge clk);
        txInfoRdEn[0] = 1'b0;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic resetValues();
        int guard;
        guard = 0;
        while (!arstN)
            stepOrTimeout("reset release", guard);
        checkFlag("recvRequest", recvRequest, 1'b0);
        checkFlag("recvReady", recvReady, 1'b0);
        checkFlag("sendRequest", sendRequest, 1'b0);
        checkFlag("sendReady", sendReady, 1'b0);
        checkFlag("curPort", curPort, 1'b0);
        checkFlag("recvFifoError[0]", recvFifoError[0], 1'b0);
        checkFlag("recvFifoError[1]", recvFifoError[1], 1'b0);
        checkFlag("sendOverflow[0]", sendOverflow[0], 1'b0);
        checkFlag("sendOverflow[1]", sendOverflow[1], 1'b0);
        checkFlag("txEmpty[0]", txEmpty[0], 1'b1);
        checkFlag("txEmpty[1]", txEmpty[1], 1'b1);
        checkFlag("txInfoEmpty[0]", txInfoEmpty[0], 1'b1);
        checkFlag("txInfoEmpty[1]", txInfoEmpty[1], 1'b1);
    endtask

    task automatic validFrame();
        sendFrame(1'b0, 8, 1'b0);
        receiveFrame(1'b0);
    endtask

    task automatic flushedFrame();
        sendFrame(1'b0, 6, 1'b1);
        repeat (40) begin                // Flushed words drain in a few cycles
            @(negedge clk);
            if (recvRequest)
                failRun("recvRequest rose for a flushed frame");
        end
        sendFrame(1'b0, 5, 1'b0);
        receiveFrame(1'b0);
    endtask

    task automatic portSwitch();
        sendFrame(1'b1, 7, 1'b0);
        receiveFrame(1'b1);
        sendFrame(1'b0, 4, 1'b0);
        receiveFrame(1'b0);              // Port 1 quiet, so back to port 0
    endtask

    task automatic responseSend();
        int guard;
        responseRequired  = 1'b1;
        responseByteCount = 12'd10;
        sendFrame(1'b0, 6, 1'b0);
        receiveFrame(1'b0);
        guard = 0;
        while (!sendRequest)
            stepOrTimeout("sendRequest", guard);
        responseRequired = 1'b0;
        respondSend(5);
        drainTx(5);
        readTxInfo(1'b0, sentQ[0][7:0], 12'd10);
        checkFlag("txEmpty[1]", txEmpty[1], 1'b1);          // Only the current port is written
        checkFlag("txInfoEmpty[1]", txInfoEmpty[1], 1'b1);
    endtask

    task automatic forwardOverflow();
        int guard;
        sendReq           = 1'b1;
        responseByteCount = 12'(2 * (dataDepth + 6));
        guard = 0;
        while (!sendRequest)
            stepOrTimeout("sendRequest", guard);
        checkFlag("isForward", isForward, 1'b1);
        sendReq = 1'b0;
        respondSend(dataDepth + 6);      // tx side left unread, queue fills
        checkFlag("sendOverflow[0]", sendOverflow[0], 1'b1);
        drainTx(dataDepth);
        checkFlag("txEmpty[0]", txEmpty[0], 1'b1);
        readTxInfo(1'b1, sentQ[0][7:0], 12'(2 * (dataDepth + 6)));
        clearErrors = 2'b01;
        @(negedge clk);
        clearErrors = '0;
        checkFlag("sendOverflow[0]", sendOverflow[0], 1'b0);
    endtask

    initial begin
        rxValid           = '0;
        rxWord            = '0;
        rxLast            = '0;
        rxBad             = '0;
        txRdEn            = '0;
        txInfoRdEn        = '0;
        initOk            = 2'b11;       // Both ports up
        clearErrors       = '0;
        sendReq           = 1'b0;
        responseRequired  = 1'b0;
        recvBusy          = 1'b0;
        sendBusy          = 1'b0;
        responseByteCount = '0;
        sendWord          = '0;
        void'($urandom(32'h139c));

        resetValues();
        validFrame();
        flushedFrame();
        portSwitch();
        responseSend();
        forwardOverflow();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/ethSwitchPkg.sv
design/queueIf.sv
design/syncFifo.sv
design/rxFrameWriter.sv
design/ethSwitchRt.sv
design/ethSwitchTop.sv
sim/clockGen.sv
sim/ethSwitchTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the switch testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ethSwitchTb -f files.f

./obj_dir/VethSwitchTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
grep -q "Done: no errors" sim.log
